//--- hw/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address layout: tag | index | word offset | byte offset
`define DC_ADDR_W      32
`define DC_INDEX_W     8
`define DC_WORD_OFS_W  2
`define DC_BYTE_OFS_W  2

// line geometry
`define DC_WORDS       4
`define DC_WAYS        2
`define DC_WORD_W      32

// derived widths
`define DC_TAG_W   (`DC_ADDR_W - `DC_INDEX_W - `DC_WORD_OFS_W - `DC_BYTE_OFS_W)
`define DC_LINE_W  (`DC_WORDS * `DC_WORD_W)

`endif

//--- hw/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]        addr_t;
    typedef logic [`DC_TAG_W-1:0]         tag_t;
    typedef logic [`DC_INDEX_W-1:0]       index_t;
    typedef logic [`DC_WORD_OFS_W-1:0]    word_ofs_t;
    typedef logic [`DC_WORD_W-1:0]        word_t;
    typedef logic [`DC_LINE_W-1:0]        line_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]  way_t;

    // byte address split into its fields
    typedef struct packed {
        tag_t                      tag;
        index_t                    index;
        word_ofs_t                 word_ofs;
        logic [`DC_BYTE_OFS_W-1:0] byte_ofs;
    } addr_fields_t;

    // one entry of a tag array
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_dirty;   // victim valid and dirty, needs write-back
    } lookup_t;

    // write side of the tag, dirty and data arrays
    typedef struct packed {
        logic [`DC_WAYS*`DC_WORDS-1:0] word_we;   // way-major
        logic [`DC_WAYS-1:0]           tag_we;
        logic [`DC_WAYS-1:0]           dirty_we;
        logic                          dirty_wd;
        logic                          src_l2;    // 1 = refill line, 0 = cpu word
        index_t                        index;
    } array_wr_t;

    typedef struct packed {
        logic  drq;
        logic  rw;      // 1 = write
        addr_t addr;
        line_t wdata;
    } l2_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WRITE_HIT,
        ST_WAIT_BUSY_CLEAN,
        ST_WAIT_BUSY_DIRTY,
        ST_WRITE_L2,
        ST_L2_ACCESS,
        ST_WRITE_L1
    } fsm_state_t;

endpackage

//--- hw/dcache_way_select.sv
`timescale 1ns/100ps

module dcache_way_select (
    input  dcache_pkg::tag_entry_t tag0_rd,
    input  dcache_pkg::tag_entry_t tag1_rd,
    input  dcache_pkg::tag_t       req_tag,
    input  logic                   dirty0,
    input  logic                   dirty1,
    input  logic                   lru,
    output dcache_pkg::lookup_t    lookup
);
    import dcache_pkg::*;

    logic hit0;
    logic hit1;
    way_t victim;
    logic victim_valid;
    logic victim_dirty_bit;

    // tag compare per way, an invalid entry never hits
    assign hit0 = tag0_rd.valid && (tag0_rd.tag == req_tag);
    assign hit1 = tag1_rd.valid && (tag1_rd.tag == req_tag);

    // victim choice
    always_comb begin
        if (!tag0_rd.valid) begin
            victim = way_t'(0);      // first free way
        end else if (!tag1_rd.valid) begin
            victim = way_t'(1);
        end else begin
            victim = way_t'(lru);    // both full, lru decides
        end
    end

    always_comb begin
        if (victim == way_t'(0)) begin
            victim_valid     = tag0_rd.valid;
            victim_dirty_bit = dirty0;
        end else begin
            victim_valid     = tag1_rd.valid;
            victim_dirty_bit = dirty1;
        end
    end

    always_comb begin
        lookup.hit          = hit0 || hit1;
        // double match should not happen, way 0 wins if it does
        lookup.hit_way      = hit0 ? way_t'(0) : way_t'(1);
        lookup.victim_way   = victim;
        lookup.victim_dirty = victim_valid && victim_dirty_bit;
    end

endmodule

//--- hw/dcache_ctrl_fsm.sv
`timescale 1ns/100ps

module dcache_ctrl_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   access_mem,
    input  logic                   memwrite,
    input  dcache_pkg::addr_t      addr,
    input  dcache_pkg::lookup_t    lookup,
    input  dcache_pkg::tag_t       victim_tag,
    input  dcache_pkg::line_t      victim_line,
    input  logic                   l2_busy,
    input  logic                   l2_rdy,
    input  logic                   l2_complete,
    input  logic                   complete,
    output dcache_pkg::fsm_state_t state,
    output logic                   miss_stall,
    output dcache_pkg::l2_req_t    l2_req
);
    import dcache_pkg::*;

    fsm_state_t   next_state;
    addr_fields_t req_f;
    addr_fields_t wb_f;      // line address of the victim
    addr_fields_t fill_f;    // line address of the request

    assign req_f = addr;

    assign wb_f = '{tag: victim_tag, index: req_f.index, word_ofs: '0, byte_ofs: '0};
    assign fill_f = '{tag: req_f.tag, index: req_f.index, word_ofs: '0, byte_ofs: '0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (access_mem) begin
                    next_state = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                if (lookup.hit) begin
                    next_state = memwrite ? ST_WRITE_HIT : ST_IDLE;
                end else if (lookup.victim_dirty) begin
                    next_state = l2_busy ? ST_WAIT_BUSY_DIRTY : ST_WRITE_L2;
                end else begin
                    next_state = l2_busy ? ST_WAIT_BUSY_CLEAN : ST_L2_ACCESS;
                end
            end
            ST_WRITE_HIT: begin
                if (complete) begin
                    next_state = ST_IDLE;
                end
            end
            ST_WAIT_BUSY_DIRTY: begin
                if (!l2_busy) begin
                    next_state = ST_WRITE_L2;
                end
            end
            ST_WAIT_BUSY_CLEAN: begin
                if (!l2_busy) begin
                    next_state = ST_L2_ACCESS;
                end
            end
            ST_WRITE_L2: begin
                // drop drq for a cycle before the refill read
                if (l2_complete) begin
                    next_state = ST_WAIT_BUSY_CLEAN;
                end
            end
            ST_L2_ACCESS: begin
                if (l2_rdy) begin
                    next_state = ST_WRITE_L1;
                end
            end
            ST_WRITE_L1: begin
                if (complete) begin
                    next_state = ST_ACCESS;    // retry, now a hit
                end
            end
        endcase
    end

    // cpu held off for the whole access
    assign miss_stall = (state != ST_IDLE);

    always_comb begin
        l2_req     = '0;
        l2_req.drq = (state == ST_WRITE_L2) || (state == ST_L2_ACCESS);
        if (state == ST_WRITE_L2) begin
            l2_req.rw    = 1'b1;
            l2_req.addr  = wb_f;
            l2_req.wdata = victim_line;
        end else if (state == ST_L2_ACCESS) begin
            l2_req.addr = fill_f;   // read, rw stays low
        end
    end

    // the decision to request was taken while l2 was idle
    a_drq_after_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(l2_req.drq) |-> !$past(l2_busy)
    ) else $error("drq rose after l2_busy was high");

    // request fields frozen for as long as drq stays up
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (l2_req.drq && $past(l2_req.drq)) |-> $stable(l2_req)
    ) else $error("l2_req changed while drq held");

endmodule

//--- hw/dcache_array_port.sv
`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache_array_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dcache_pkg::fsm_state_t state,
    input  dcache_pkg::lookup_t    lookup,
    input  dcache_pkg::addr_t      addr,
    input  dcache_pkg::line_t      data0_rd,
    input  dcache_pkg::line_t      data1_rd,
    output dcache_pkg::array_wr_t  array_wr,
    output dcache_pkg::word_t      read_data_m
);
    import dcache_pkg::*;

    addr_fields_t                         req_f;
    way_t                                 refill_way;
    line_t                                hit_line;
    logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] hit_words;
    logic [`DC_WAYS-1:0][`DC_WORDS-1:0]   word_we_w;   // strobes seen per way
    logic [`DC_WAYS-1:0]                  way_busy;

    assign req_f = addr;

    // victim held from the miss decision, the tag write would move it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refill_way <= '0;
        end else if (state == ST_ACCESS) begin
            refill_way <= lookup.victim_way;
        end
    end

    always_comb begin
        array_wr       = '0;
        array_wr.index = req_f.index;
        case (state)
            ST_WRITE_HIT: begin
                array_wr.word_we[{lookup.hit_way, req_f.word_ofs}] = 1'b1;
                array_wr.tag_we[lookup.hit_way]   = 1'b1;
                array_wr.dirty_we[lookup.hit_way] = 1'b1;
                array_wr.dirty_wd                 = 1'b1;
            end
            ST_WRITE_L1: begin
                // whole line from l2, comes in clean
                array_wr.word_we[{refill_way, word_ofs_t'(0)} +: `DC_WORDS] = '1;
                array_wr.tag_we[refill_way]   = 1'b1;
                array_wr.dirty_we[refill_way] = 1'b1;
                array_wr.src_l2               = 1'b1;
            end
            default: ;
        endcase
    end

    assign hit_line  = (lookup.hit_way == way_t'(0)) ? data0_rd : data1_rd;
    assign hit_words = hit_line;

    // captured on every ACCESS hit, a read leaves IDLE with it next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data_m <= '0;
        end else if (state == ST_ACCESS && lookup.hit) begin
            read_data_m <= hit_words[req_f.word_ofs];
        end
    end

    assign word_we_w = array_wr.word_we;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_busy[w] = |word_we_w[w];
        end
    end

    a_one_way: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(way_busy) && ((state != ST_WRITE_HIT) || $onehot(array_wr.word_we))
    ) else $error("word strobes span both ways");

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // cpu side
    input  logic                   access_mem,
    input  logic                   memwrite,
    input  dcache_pkg::addr_t      addr,
    output dcache_pkg::word_t      read_data_m,
    output logic                   miss_stall,
    // tag, dirty and data arrays
    input  dcache_pkg::tag_entry_t tag0_rd,
    input  dcache_pkg::tag_entry_t tag1_rd,
    input  dcache_pkg::line_t      data0_rd,
    input  dcache_pkg::line_t      data1_rd,
    input  logic                   dirty0,
    input  logic                   dirty1,
    input  logic                   lru,
    input  logic                   complete,
    output dcache_pkg::array_wr_t  array_wr,
    output dcache_pkg::tag_entry_t tag_wd,
    // l2 side
    input  logic                   l2_busy,
    input  logic                   l2_rdy,
    input  logic                   l2_complete,
    output dcache_pkg::l2_req_t    l2_req
);
    import dcache_pkg::*;

    addr_fields_t req_f;
    lookup_t      lookup;
    fsm_state_t   state;
    tag_t         victim_tag;
    line_t        victim_line;

    assign req_f = addr;

    // new tag always lands valid
    assign tag_wd = '{valid: 1'b1, tag: req_f.tag};

    assign victim_tag  = (lookup.victim_way == way_t'(0)) ? tag0_rd.tag : tag1_rd.tag;
    assign victim_line = (lookup.victim_way == way_t'(0)) ? data0_rd : data1_rd;

    dcache_way_select u_way_select (
        .tag0_rd (tag0_rd),
        .tag1_rd (tag1_rd),
        .req_tag (req_f.tag),
        .dirty0  (dirty0),
        .dirty1  (dirty1),
        .lru     (lru),
        .lookup  (lookup)
    );

    dcache_ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .access_mem  (access_mem),
        .memwrite    (memwrite),
        .addr        (addr),
        .lookup      (lookup),
        .victim_tag  (victim_tag),
        .victim_line (victim_line),
        .l2_busy     (l2_busy),
        .l2_rdy      (l2_rdy),
        .l2_complete (l2_complete),
        .complete    (complete),
        .state       (state),
        .miss_stall  (miss_stall),
        .l2_req      (l2_req)
    );

    dcache_array_port u_array_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .lookup      (lookup),
        .addr        (addr),
        .data0_rd    (data0_rd),
        .data1_rd    (data1_rd),
        .array_wr    (array_wr),
        .read_data_m (read_data_m)
    );

endmodule

//--- bench/dcache_tb_model.sv
`timescale 1ns/100ps

module dcache_tb_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   access_mem,
    input  dcache_pkg::word_t      cpu_wdata,
    input  dcache_pkg::array_wr_t  array_wr,
    input  dcache_pkg::tag_entry_t tag_wd,
    output dcache_pkg::tag_entry_t tag0_rd,
    output dcache_pkg::tag_entry_t tag1_rd,
    output dcache_pkg::line_t      data0_rd,
    output dcache_pkg::line_t      data1_rd,
    output logic                   dirty0,
    output logic                   dirty1,
    output logic                   lru,
    output logic                   complete,
    input  dcache_pkg::l2_req_t    l2_req,
    output logic                   l2_busy,
    output logic                   l2_rdy,
    output logic                   l2_complete
);
    import dcache_pkg::*;

    tag_entry_t        tag_mem [2][256];
    logic              dirty_mem [2][256];
    logic [3:0][31:0]  data_mem [2][256];
    logic              lru_mem [256];
    word_t             l2_mem [4096];    // 16 KB backing store, tags 0 to 3
    logic [3:0][31:0]  l2_rdata;         // last refill line, held for WRITE_L1
    logic [3:0][31:0]  wb_words;
    logic [11:0]       l2_base;
    integer            seed;
    int                lat;
    int                busy_cnt;
    logic              active;

    initial begin
        seed = 6646;
        for (int i = 0; i < 4096; i++) begin
            l2_mem[i] = $random(seed);
        end
    end

    assign tag0_rd  = tag_mem[0][array_wr.index];
    assign tag1_rd  = tag_mem[1][array_wr.index];
    assign data0_rd = data_mem[0][array_wr.index];
    assign data1_rd = data_mem[1][array_wr.index];
    assign dirty0   = dirty_mem[0][array_wr.index];
    assign dirty1   = dirty_mem[1][array_wr.index];
    assign lru      = lru_mem[array_wr.index];
    assign l2_busy  = (busy_cnt != 0);
    assign l2_base  = l2_req.addr[13:2];   // word 0 of the line
    assign wb_words = l2_req.wdata;

    // tag, dirty and data arrays, one complete pulse per burst
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            complete <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                tag_mem[0][i]   <= '0;
                tag_mem[1][i]   <= '0;
                dirty_mem[0][i] <= 1'b0;
                dirty_mem[1][i] <= 1'b0;
                lru_mem[i]      <= 1'b0;
            end
        end else if (|array_wr.word_we && !complete) begin
            complete <= 1'b1;
            for (int w = 0; w < 2; w++) begin
                if (array_wr.tag_we[w]) begin
                    tag_mem[w[0]][array_wr.index] <= tag_wd;
                end
                if (array_wr.dirty_we[w]) begin
                    dirty_mem[w[0]][array_wr.index] <= array_wr.dirty_wd;
                end
                for (int k = 0; k < 4; k++) begin
                    if (array_wr.word_we[w*4+k]) begin
                        data_mem[w[0]][array_wr.index][k[1:0]] <=
                            array_wr.src_l2 ? l2_rdata[k[1:0]] : cpu_wdata;
                    end
                end
                if (|array_wr.word_we[w*4 +: 4]) begin
                    lru_mem[array_wr.index] <= (w == 0);   // other way now least recent
                end
            end
        end else begin
            complete <= 1'b0;
        end
    end

    // l2 with random latency and bursts of foreign traffic
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l2_rdy      <= 1'b0;
            l2_complete <= 1'b0;
            active      <= 1'b0;
            lat         <= 0;
            busy_cnt    <= 0;
            l2_rdata    <= '0;
        end else begin
            l2_rdy      <= 1'b0;
            l2_complete <= 1'b0;
            if (busy_cnt != 0) begin
                busy_cnt <= busy_cnt - 1;
            end else if (access_mem || l2_complete) begin
                busy_cnt <= int'($unsigned($random(seed)) % 4);   // 0 means no traffic
            end
            if (l2_req.drq && !active && !l2_rdy && !l2_complete) begin
                active <= 1'b1;
                lat    <= 1 + int'($unsigned($random(seed)) % 4);
            end else if (active && lat > 1) begin
                lat <= lat - 1;
            end else if (active) begin
                active <= 1'b0;
                if (l2_req.rw) begin
                    for (int k = 0; k < 4; k++) begin
                        l2_mem[l2_base + 12'(k)] <= wb_words[k[1:0]];
                    end
                    l2_complete <= 1'b1;
                end else begin
                    for (int k = 0; k < 4; k++) begin
                        l2_rdata[k[1:0]] <= l2_mem[l2_base + 12'(k)];
                    end
                    l2_rdy <= 1'b1;
                end
            end
        end
    end

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       access_mem;
    logic       memwrite;
    addr_t      addr;
    word_t      cpu_wdata;
    word_t      read_data_m;
    logic       miss_stall;
    tag_entry_t tag0_rd;
    tag_entry_t tag1_rd;
    line_t      data0_rd;
    line_t      data1_rd;
    logic       dirty0;
    logic       dirty1;
    logic       lru;
    logic       complete;
    array_wr_t  array_wr;
    tag_entry_t tag_wd;
    logic       l2_busy;
    logic       l2_rdy;
    logic       l2_complete;
    l2_req_t    l2_req;

    logic       started;      // first access issued
    logic       stall_q;
    way_t       exp_way;      // victim as seen at the miss
    logic       exp_wb;
    tag_t       exp_vtag;
    line_t      exp_vline;
    logic       wb_done;
    logic [1:0] tag_match;    // ways holding the request tag
    word_t      written [int];
    integer     seed;

    dcache_top UUT (.*);

    dcache_tb_model mem_model (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic addr_t make_addr(input tag_t t, input index_t i, input word_ofs_t w);
        return {t, i, w, 2'b00};
    endfunction

    function automatic logic victim_for(input logic v0, input logic v1, input logic lru_bit);
        if (!v0) return 1'b0;
        if (!v1) return 1'b1;
        return lru_bit;
    endfunction

    // last cpu write wins, else the untouched l2 word
    function automatic word_t expected_word(input addr_t a);
        if (written.exists(int'(a[13:2]))) return written[int'(a[13:2])];
        return mem_model.l2_mem[a[13:2]];
    endfunction

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string why);
        $display("%0t: %s", $time, why);
        stop_on_failure();
    endtask

    task automatic report_value_error(input string name, input logic [127:0] got,
                                      input logic [127:0] exp);
        $display("** Error: %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        stop_on_failure();
    endtask

    task automatic do_access(input logic wr, input addr_t a, input word_t d);
        int t;
        access_mem = 1'b1;
        memwrite   = wr;
        addr       = a;
        cpu_wdata  = d;
        started    = 1'b1;
        @(negedge clk);
        access_mem = 1'b0;
        t = 0;
        while (miss_stall) begin
            @(negedge clk);
            t++;
            if (t > 200) report_failure("timeout waiting for miss_stall to fall");
        end
        @(negedge clk);   // keep addr for the read check
        if (wr) written[int'(a[13:2])] = d;
    endtask

    assign tag_match = {tag1_rd.valid && tag1_rd.tag == addr[31:12],
                        tag0_rd.valid && tag0_rd.tag == addr[31:12]};

    always @(posedge clk or negedge rst_n) begin : capture_victim
        logic w;
        if (!rst_n) begin
            stall_q   <= 1'b0;
            exp_way   <= '0;
            exp_wb    <= 1'b0;
            exp_vtag  <= '0;
            exp_vline <= '0;
            wb_done   <= 1'b0;
        end else begin
            stall_q <= miss_stall;
            if (miss_stall && !stall_q) begin   // first ACCESS cycle
                w = victim_for(tag0_rd.valid, tag1_rd.valid, lru);
                exp_way   <= w;
                exp_wb    <= w ? (tag1_rd.valid && dirty1) : (tag0_rd.valid && dirty0);
                exp_vtag  <= w ? tag1_rd.tag : tag0_rd.tag;
                exp_vline <= w ? data1_rd : data0_rd;
                wb_done   <= 1'b0;
            end else if (l2_complete) begin
                wb_done <= 1'b1;
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !miss_stall && !l2_req.drq && array_wr.word_we == '0
            && array_wr.tag_we == '0 && array_wr.dirty_we == '0 && read_data_m == '0)
        else report_failure("outputs active before the first access");

    a_fill_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_req.drq) && !l2_req.rw |-> l2_req.addr == {addr[31:4], 4'h0})
        else report_value_error("l2_req.addr", 128'($sampled(l2_req.addr)),
                                128'({$sampled(addr[31:4]), 4'h0}));

    a_fill_way: assert property (@(posedge clk) disable iff (!rst_n)
        array_wr.src_l2 |-> array_wr.word_we == (exp_way ? 8'hf0 : 8'h0f) && !array_wr.dirty_wd)
        else report_value_error("array_wr.word_we", 128'($sampled(array_wr.word_we)),
                                128'($sampled(exp_way) ? 8'hf0 : 8'h0f));

    a_hit_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        (array_wr.word_we != '0 && !array_wr.src_l2) |->
            array_wr.word_we == 8'({3'b000, tag_match[1], 3'b000, tag_match[0]} << addr[3:2])
            && array_wr.dirty_wd && memwrite)
        else report_value_error("array_wr.word_we", 128'($sampled(array_wr.word_we)),
                                128'(8'({3'b000, $sampled(tag_match[1]), 3'b000,
                                         $sampled(tag_match[0])} << $sampled(addr[3:2]))));

    a_tag_write: assert property (@(posedge clk) disable iff (!rst_n)
        array_wr.tag_we != '0 |-> tag_wd == {1'b1, addr[31:12]})
        else report_value_error("tag_wd", 128'($sampled(tag_wd)),
                                128'({1'b1, $sampled(addr[31:12])}));

    a_wb_needed: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_req.drq) && l2_req.rw |-> exp_wb)
        else report_failure("L2 write issued without a dirty victim");

    a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_req.drq) && l2_req.rw |-> l2_req.addr == {exp_vtag, addr[11:4], 4'h0})
        else report_value_error("l2_req.addr", 128'($sampled(l2_req.addr)),
                                128'({$sampled(exp_vtag), $sampled(addr[11:4]), 4'h0}));

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_req.drq) && l2_req.rw |-> l2_req.wdata == exp_vline)
        else report_value_error("l2_req.wdata", $sampled(l2_req.wdata), $sampled(exp_vline));

    a_wb_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_req.drq) && !l2_req.rw |-> !exp_wb || wb_done)
        else report_failure("refill read issued before the write-back finished");

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        l2_busy |-> !l2_req.drq)
        else report_failure("drq high while l2_busy");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $past(l2_req.drq) && !$past(l2_rdy) && !$past(l2_complete) |->
            l2_req.drq && $stable(l2_req))
        else report_failure("L2 request dropped or changed before it ended");

    a_drop: assert property (@(posedge clk) disable iff (!rst_n)
        l2_rdy || l2_complete |=> !l2_req.drq)
        else report_failure("drq still high after the ending strobe");

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(miss_stall) && !memwrite |-> read_data_m == expected_word(addr))
        else report_value_error("read_data_m", 128'($sampled(read_data_m)),
                                128'(expected_word($sampled(addr))));

    initial begin
        logic [31:0] r;
        seed       = 6646;
        rst_n      = 1'b0;
        access_mem = 1'b0;
        memwrite   = 1'b0;
        addr       = '0;
        cpu_wdata  = '0;
        started    = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        do_access(1'b0, make_addr(20'h1, 8'h05, 2'd2), '0);            // clean miss, way 0
        do_access(1'b1, make_addr(20'h1, 8'h05, 2'd1), 32'hcafe_0001); // write hit
        do_access(1'b0, make_addr(20'h1, 8'h05, 2'd1), '0);
        do_access(1'b0, make_addr(20'h2, 8'h05, 2'd0), '0);            // fills way 1
        do_access(1'b0, make_addr(20'h3, 8'h05, 2'd3), '0);            // dirty lru victim
        do_access(1'b1, make_addr(20'h1, 8'h05, 2'd1), 32'h5a5a_0002); // write miss
        do_access(1'b0, make_addr(20'h1, 8'h05, 2'd1), '0);
        // mixed traffic over a few sets
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            do_access(r[0], make_addr(tag_t'(r[2:1]), index_t'(r[4:3]), word_ofs_t'(r[6:5])),
                      $random(seed));
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_way_select.sv
hw/dcache_ctrl_fsm.sv
hw/dcache_array_port.sv
hw/dcache_top.sv
bench/dcache_tb_model.sv
bench/dcache_tb.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat sources.f)) hw/dcache_config.svh

.PHONY: all run clean

all: obj_dir/Vdcache_tb

obj_dir/Vdcache_tb: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module dcache_tb -o Vdcache_tb

run: obj_dir/Vdcache_tb
	@out=$$(./obj_dir/Vdcache_tb 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
